// File: project.f
rtl/fm_timer_pkg.sv
rtl/fm_tick_gen.sv
rtl/fm_timer_regs.sv
rtl/fm_timer.sv
rtl/fm_timers.sv
rtl/fm_timer_top.sv
testbench/fm_timer_checker.sv
testbench/tb_fm_timer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the FM timer testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -Wno-fatal --top-module tb_fm_timer \
	-f project.f -o sim_fm_timer

out=$(./obj_dir/sim_fm_timer)
echo "$out"

if grep -qF -- "** PASS **" <<< "$out"; then
	exit 0
fi
exit 1

// File: testbench/tb_fm_timer.sv
//////////////////////////////
// FM timer testbench
// Host writes, timer periods, flags and IRQ
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_fm_timer;

	import fm_timer_pkg::*;

	localparam int         DIV         = 2;
	localparam int         NUM_CH      = 6;
	localparam int         clk_ns      = 4;        // Clock period.
	localparam int         sample_clks = DIV * 24; // Clocks per sample tick.
	localparam logic [7:0] ctrl_load_a = 8'h01;    // Bits of the 0x27 byte.
	localparam logic [7:0] ctrl_load_b = 8'h02;
	localparam logic [7:0] ctrl_en_a   = 8'h04;
	localparam logic [7:0] ctrl_rst_a  = 8'h10;
	localparam logic [7:0] ctrl_rst_b  = 8'h20;

	logic            clk;
	logic            rst;
	logic            wr;
	logic [7:0]      addr;
	logic [7:0]      din;
	wire  [7:0]      dout;
	wire             irq_n;
	wire             overflow_a;
	int              test_id;
	logic [ta_w-1:0] na;          // Timer A start value.
	logic [tb_w-1:0] nb;          // Timer B start value.
	logic            check_a;
	logic            check_b;
	logic            check_dout;
	logic [7:0]      dout_mask;
	logic [7:0]      exp_dout;
	logic            check_irq;
	logic            exp_irq_n;
	logic            no_ovf;
	int              period_errs;
	int              value_errs;
	int              wait_errs;   // Timeouts in the wait tasks.
	int unsigned     seed;
	int              pa_clks;     // Nominal timer A period.
	int              pb_clks;     // Nominal timer B period.
	int              limit_ns;
	logic            limit_ready;

	fm_timer_top #(.DIV(DIV), .NUM_CH(NUM_CH)) dut (
		.clk(clk), .rst(rst), .wr(wr), .addr(addr), .din(din),
		.dout(dout), .irq_n(irq_n), .overflow_a(overflow_a)
	);

	fm_timer_checker #(.DIV(DIV), .NUM_CH(NUM_CH)) chk (
		.clk(clk), .rst(rst), .dout(dout), .irq_n(irq_n), .overflow_a(overflow_a),
		.na(na), .nb(nb), .test_id(test_id), .check_a(check_a), .check_b(check_b),
		.check_dout(check_dout), .dout_mask(dout_mask), .exp_dout(exp_dout),
		.check_irq(check_irq), .exp_irq_n(exp_irq_n), .no_ovf(no_ovf),
		.period_errs(period_errs), .value_errs(value_errs)
	);

	initial clk = 1'b0;
	always #(clk_ns / 2) clk = ~clk;

	// Watchdog, armed once the periods are known.
	initial begin
		wait (limit_ready);
		#(limit_ns);
		$display("Watchdog timeout after %0d ns in test %0d", limit_ns, test_id);
		$display("** FAIL **");
		$finish;
	end

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// One host write; returns a clock after, once clear pulses have landed.
	task automatic host_write(input logic [7:0] a, input logic [7:0] d);
		@(negedge clk);
		wr   = 1'b1;
		addr = a;
		din  = d;
		@(negedge clk);
		wr = 1'b0;
		@(negedge clk);
	endtask

	task automatic wait_clocks(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic wait_overflow_a(input int max_clks);
		int n;
		n = 0;
		@(negedge clk);
		while (overflow_a !== 1'b1 && n < max_clks) begin
			@(negedge clk);
			n++;
		end
		if (overflow_a !== 1'b1) begin
			$display("No overflow_a pulse within %0d clocks in test %0d", max_clks, test_id);
			wait_errs++;
		end
	endtask

	task automatic wait_status_bit(input logic [2:0] idx, input logic val, input int max_clks);
		int n;
		n = 0;
		@(negedge clk);
		while (dout[idx] !== val && n < max_clks) begin
			@(negedge clk);
			n++;
		end
		if (dout[idx] !== val) begin
			$display("Status bit %0d never became %0b in test %0d", idx, val, test_id);
			wait_errs++;
		end
	endtask

	initial begin
		rst = 1'b1;
		wr  = 1'b0;
		addr = 8'h00;
		din  = 8'h00;
		test_id <= 0;
		check_a <= 1'b0;
		check_b <= 1'b0;
		check_dout <= 1'b0;
		dout_mask <= 8'h00;
		exp_dout <= 8'h00;
		check_irq <= 1'b0;
		exp_irq_n <= 1'b1;
		no_ovf <= 1'b0;
		wait_errs = 0;
		limit_ready = 1'b0;
		seed = 32'd6549;
		seed = lcg_next(seed);
		na = ta_w'(32'd1016 + (seed >> 16) % 32'd7); // 1016 to 1022.
		seed = lcg_next(seed);
		nb = tb_w'(32'd253 + (seed >> 16) % 32'd3);  // 253 to 255.
		pa_clks = ((1 << ta_w) - int'(na)) * sample_clks;
		pb_clks = 16 * ((1 << tb_w) - int'(nb)) * sample_clks;
		limit_ns = 3 * clk_ns * (4 * sample_clks + 17 * pa_clks + 6 * pb_clks);
		limit_ready = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Idle after reset.
		test_id <= 1;
		dout_mask <= 8'hff;
		check_dout <= 1'b1;
		check_irq <= 1'b1;
		no_ovf <= 1'b1;
		wait_clocks(4 * sample_clks);

		// Timer A period and status bit 0.
		test_id <= 2;
		check_dout <= 1'b0;
		no_ovf <= 1'b0;
		host_write(addr_ta_hi, na[ta_w-1:2]);
		host_write(addr_ta_lo, {6'd0, na[1:0]});
		host_write(addr_ctrl, ctrl_load_a);
		check_a <= 1'b1;
		repeat (5) wait_overflow_a(2 * pa_clks + 2 * sample_clks);
		wait_clocks(2);
		dout_mask <= 8'h01;
		exp_dout <= 8'h01;
		check_dout <= 1'b1;
		wait_clocks(sample_clks);

		// Timer B period, flag cleared after each rise.
		test_id <= 3;
		host_write(addr_tb, nb);
		host_write(addr_ctrl, ctrl_load_a | ctrl_load_b);
		check_b <= 1'b1;
		repeat (4) begin
			wait_status_bit(3'd1, 1'b1, 2 * pb_clks + 32 * sample_clks);
			host_write(addr_ctrl, ctrl_load_a | ctrl_load_b | ctrl_rst_b);
			wait_status_bit(3'd1, 1'b0, 2); // Flag B must be down again.
		end
		wait_status_bit(3'd1, 1'b1, 2 * pb_clks); // flag_b stays up from here on.
		check_b <= 1'b0;

		// Flag A without enable, then with enable.
		test_id <= 4;
		check_dout <= 1'b0;
		wait_overflow_a(2 * pa_clks);
		host_write(addr_ctrl, ctrl_load_a | ctrl_load_b | ctrl_rst_a);
		wait_status_bit(3'd0, 1'b1, 2 * pa_clks);
		check_irq <= 1'b0;
		host_write(addr_ctrl, ctrl_load_a | ctrl_load_b | ctrl_en_a);
		exp_irq_n <= 1'b0;
		check_irq <= 1'b1;
		wait_clocks(sample_clks);

		// Clear flag A right after an overflow.
		test_id <= 5;
		check_irq <= 1'b0;
		wait_overflow_a(2 * pa_clks);
		host_write(addr_ctrl, ctrl_load_a | ctrl_load_b | ctrl_en_a | ctrl_rst_a);
		dout_mask <= 8'h03;
		exp_dout <= 8'h02;
		check_dout <= 1'b1;
		exp_irq_n <= 1'b1;
		check_irq <= 1'b1;
		wait_clocks(sample_clks / 2);
		dout_mask <= 8'h02;
		check_irq <= 1'b0;
		wait_status_bit(3'd0, 1'b1, 2 * pa_clks);
		exp_irq_n <= 1'b0;
		check_irq <= 1'b1;
		wait_clocks(4);

		// Stop timer A; one more overflow may still land.
		test_id <= 6;
		check_a <= 1'b0;
		check_dout <= 1'b0;
		check_irq <= 1'b0;
		host_write(addr_ctrl, ctrl_load_b);
		wait_clocks(pa_clks + 2 * sample_clks);
		host_write(addr_ctrl, ctrl_load_b | ctrl_rst_a);
		dout_mask <= 8'h01;
		exp_dout <= 8'h00;
		check_dout <= 1'b1;
		exp_irq_n <= 1'b1;
		check_irq <= 1'b1;
		no_ovf <= 1'b1;
		wait_clocks(3 * pa_clks);
		check_dout <= 1'b0;
		check_irq <= 1'b0;
		no_ovf <= 1'b0;
		wait_clocks(2);

		$display("Errors: period %0d, value %0d, timeout %0d", period_errs, value_errs, wait_errs);
		if (period_errs + value_errs + wait_errs == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/fm_timer_checker.sv
//////////////////////////////
// FM timer checker
// Times timer events, checks status and IRQ
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module fm_timer_checker #(
	parameter int DIV    = 2, // Clocks per operator slot.
	parameter int NUM_CH = 6  // Channel count of the build.
) (
	input  wire                           clk,
	input  wire                           rst,
	input  wire  [7:0]                    dout,
	input  wire                           irq_n,
	input  wire                           overflow_a,
	input  wire  [fm_timer_pkg::ta_w-1:0] na,         // Timer A start value.
	input  wire  [fm_timer_pkg::tb_w-1:0] nb,         // Timer B start value.
	input  int                            test_id,
	input  wire                           check_a,    // Time overflow_a spacing.
	input  wire                           check_b,    // Time flag_b rises.
	input  wire                           check_dout,
	input  wire  [7:0]                    dout_mask,
	input  wire  [7:0]                    exp_dout,
	input  wire                           check_irq,
	input  wire                           exp_irq_n,
	input  wire                           no_ovf,     // Timer A must be silent.
	output int                            period_errs,
	output int                            value_errs
);

	import fm_timer_pkg::*;

	localparam int slots   = 24;                      // Operator slots per sample.
	localparam int b_steps = (NUM_CH == 3) ? 32 : 16; // Samples per timer B step.

	int   cycle;    // Clocks since reset.
	int   last_a;   // Clock of last overflow_a, -1 for none yet.
	int   last_b;   // Clock of last flag_b rise.
	logic flag_b_d; // flag_b one clock back.

	// Expected clocks for a number of sample ticks.
	function automatic int period_clocks(input int ticks);
		return ticks * DIV * slots;
	endfunction

	function automatic string test_name(input int id);
		case (id)
			1:       return "reset_idle";
			2:       return "timer_a_period";
			3:       return "timer_b_period";
			4:       return "irq_enable";
			5:       return "flag_a_clear";
			6:       return "timer_a_stop";
			default: return "startup";
		endcase
	endfunction

	task automatic check_period(input int exp_clks, input int act_clks, input int tol);
		if (act_clks < exp_clks - tol || act_clks > exp_clks + tol) begin
			$display("Fail %s: expected %0d clocks, actual %0d clocks",
				test_name(test_id), exp_clks, act_clks);
			period_errs = period_errs + 1;
		end
	endtask

	// Outputs settle after posedge, so look at them on the falling edge.
	always @(negedge clk) begin
		if (rst) begin
			cycle       = 0;
			last_a      = -1;
			last_b      = -1;
			flag_b_d    = 1'b0;
			period_errs = 0;
			value_errs  = 0;
		end else begin
			cycle = cycle + 1;
			if (!check_a) begin
				last_a = -1;
			end else if (overflow_a) begin
				if (last_a >= 0) begin // First pulse after load only starts the clock.
					check_period(period_clocks((1 << ta_w) - int'(na)), cycle - last_a,
						period_clocks(1));
				end
				last_a = cycle;
			end
			if (!check_b) begin
				last_b = -1;
			end else if (dout[1] && !flag_b_d) begin
				if (last_b >= 0) begin
					check_period(period_clocks(b_steps * ((1 << tb_w) - int'(nb))),
						cycle - last_b, period_clocks(b_steps));
				end
				last_b = cycle;
			end
			flag_b_d = dout[1];
			if (check_dout && ((dout & dout_mask) != (exp_dout & dout_mask))) begin
				$display("Fail %s: status expected %02h, actual %02h", test_name(test_id),
					exp_dout & dout_mask, dout & dout_mask);
				value_errs = value_errs + 1;
			end
			if (check_irq && (irq_n != exp_irq_n)) begin
				$display("Fail %s: irq_n expected %0b, actual %0b", test_name(test_id),
					exp_irq_n, irq_n);
				value_errs = value_errs + 1;
			end
			if (no_ovf && overflow_a) begin
				$display("Timer A overflowed while not running (test %s)", test_name(test_id));
				value_errs = value_errs + 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/fm_timer_top.sv
//////////////////////////////
// FM timer section top
// Ticks, host registers, timers and status
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module fm_timer_top #(
	parameter int DIV    = 2, // Clocks per operator slot.
	parameter int NUM_CH = 6  // Channel count of the build.
) (
	input  wire        clk,
	input  wire        rst,
	input  wire        wr,
	input  wire  [7:0] addr,
	input  wire  [7:0] din,
	output logic [7:0] dout,
	output logic       irq_n,
	output logic       overflow_a
);

	import fm_timer_pkg::*;

	logic            cen;      // Operator clock enable.
	logic            zero;     // Sample tick.
	logic [ta_w-1:0] value_a;
	logic [tb_w-1:0] value_b;
	logic            load_a;
	logic            load_b;
	logic            en_irq_a;
	logic            en_irq_b;
	logic            clr_a;
	logic            clr_b;
	logic            flag_a;
	logic            flag_b;

	// Status byte, flags in the low bits.
	assign dout = {6'd0, flag_b, flag_a};

	fm_tick_gen #(.DIV(DIV)) u_tick_gen (
		.clk  (clk),
		.rst  (rst),
		.cen  (cen),
		.zero (zero)
	);

	fm_timer_regs u_regs (
		.clk      (clk),
		.rst      (rst),
		.wr       (wr),
		.addr     (addr),
		.din      (din),
		.value_a  (value_a),
		.value_b  (value_b),
		.load_a   (load_a),
		.load_b   (load_b),
		.en_irq_a (en_irq_a),
		.en_irq_b (en_irq_b),
		.clr_a    (clr_a),
		.clr_b    (clr_b)
	);

	fm_timers #(.NUM_CH(NUM_CH)) u_timers (
		.clk        (clk),
		.rst        (rst),
		.cen        (cen),
		.zero       (zero),
		.value_a    (value_a),
		.value_b    (value_b),
		.load_a     (load_a),
		.load_b     (load_b),
		.clr_a      (clr_a),
		.clr_b      (clr_b),
		.en_irq_a   (en_irq_a),
		.en_irq_b   (en_irq_b),
		.flag_a     (flag_a),
		.flag_b     (flag_b),
		.overflow_a (overflow_a),
		.irq_n      (irq_n)
	);

endmodule

`default_nettype wire

// File: rtl/fm_timers.sv
//////////////////////////////
// FM timer pair
// Timers A and B with IRQ output
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module fm_timers #(
	parameter int NUM_CH = 6 // 6 or 3 channel build.
) (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           cen,
	input  wire                           zero,
	input  wire  [fm_timer_pkg::ta_w-1:0] value_a,
	input  wire  [fm_timer_pkg::tb_w-1:0] value_b,
	input  wire                           load_a,
	input  wire                           load_b,
	input  wire                           clr_a,
	input  wire                           clr_b,
	input  wire                           en_irq_a,
	input  wire                           en_irq_b,
	output logic                          flag_a,
	output logic                          flag_b,
	output logic                          overflow_a,
	output logic                          irq_n
);

	import fm_timer_pkg::*;

	// Active low when any enabled flag is up.
	assign irq_n = ~((flag_a && en_irq_a) || (flag_b && en_irq_b));

	// Timer A steps every sample, every second one in the 3-channel build.
	fm_timer #(.CW(ta_w), .FW(1), .FREE_EN(NUM_CH == 3)) u_timer_a (
		.clk         (clk),
		.rst         (rst),
		.cen         (cen),
		.zero        (zero),
		.start_value (value_a),
		.load        (load_a),
		.clr_flag    (clr_a),
		.flag        (flag_a),
		.overflow    (overflow_a)
	);

	// Timer B steps every 16 samples, 32 in the 3-channel build.
	fm_timer #(.CW(tb_w), .FW(NUM_CH == 3 ? 5 : 4), .FREE_EN(1'b1)) u_timer_b (
		.clk         (clk),
		.rst         (rst),
		.cen         (cen),
		.zero        (zero),
		.start_value (value_b),
		.load        (load_b),
		.clr_flag    (clr_b),
		.flag        (flag_b),
		.overflow    ()
	);

endmodule

`default_nettype wire

// File: rtl/fm_timer.sv
//////////////////////////////
// FM timer counter
// Loadable up-counter with sticky overflow flag
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module fm_timer #(
	parameter int CW      = 8,   // Loadable counter width.
	parameter int FW      = 1,   // Free-running prescale width.
	parameter bit FREE_EN = 1'b0 // Step only on prescale carry.
) (
	input  wire           clk,
	input  wire           rst,
	input  wire           cen,
	input  wire           zero,
	input  wire  [CW-1:0] start_value,
	input  wire           load,
	input  wire           clr_flag,
	output logic          flag,
	output logic          overflow
);

	logic          tick;      // One per sample.
	logic          last_load; // Load as sampled at the last tick.
	logic [CW-1:0] cnt;
	logic [FW-1:0] free_cnt;  // Sample prescaler.
	logic          free_ov;   // Prescaler about to wrap.
	logic          advance;   // Counter steps on this tick.

	assign tick     = cen && zero;
	assign free_ov  = &free_cnt;
	assign advance  = FREE_EN ? free_ov : 1'b1;
	assign overflow = tick && last_load && (&cnt) && advance; // Max and stepping.

	// Main counter. Loads on the rising edge of load, reloads on overflow.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			last_load <= 1'b0;
			cnt       <= '0;
		end else if (tick) begin
			last_load <= load;
			if ((load && !last_load) || overflow) begin
				cnt <= start_value;
			end else if (last_load && advance) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// Free prescaler runs whether or not the timer is loaded.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			free_cnt <= '0;
		end else if (tick) begin
			free_cnt <= free_cnt + 1'b1;
		end
	end

	// Sticky flag. Clear beats set.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			flag <= 1'b0;
		end else if (clr_flag) begin
			flag <= 1'b0;
		end else if (overflow) begin
			flag <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/fm_timer_regs.sv
//////////////////////////////
// FM timer register block
// Host writes to timer values, run/IRQ bits, clears
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module fm_timer_regs (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           wr,
	input  wire  [7:0]                    addr,
	input  wire  [7:0]                    din,
	output logic [fm_timer_pkg::ta_w-1:0] value_a,
	output logic [fm_timer_pkg::tb_w-1:0] value_b,
	output logic                          load_a,
	output logic                          load_b,
	output logic                          en_irq_a,
	output logic                          en_irq_b,
	output logic                          clr_a,
	output logic                          clr_b
);

	import fm_timer_pkg::*;

	timer_ctrl_u ctrl;     // Write data decoded as control byte.
	logic        wr_ta_hi; // Write strobes per address.
	logic        wr_ta_lo;
	logic        wr_tb;
	logic        wr_ctrl;

	always_comb begin
		ctrl.raw = din;
	end

	assign wr_ta_hi = wr && (addr == addr_ta_hi);
	assign wr_ta_lo = wr && (addr == addr_ta_lo);
	assign wr_tb    = wr && (addr == addr_tb);
	assign wr_ctrl  = wr && (addr == addr_ctrl);

	// Timer start values.
	always_ff @(posedge clk) begin
		if (wr_ta_hi) begin
			value_a[ta_w-1:2] <= din[ta_w-3:0]; // Upper 8 bits.
		end
		if (wr_ta_lo) begin
			value_a[1:0] <= din[1:0]; // Lower 2 bits.
		end
		if (wr_tb) begin
			value_b <= din[tb_w-1:0];
		end
	end

	// Run and IRQ enable bits are kept; reset bits are only strobes.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			load_a   <= 1'b0;
			load_b   <= 1'b0;
			en_irq_a <= 1'b0;
			en_irq_b <= 1'b0;
		end else if (wr_ctrl) begin
			load_a   <= ctrl.fields.load_a;
			load_b   <= ctrl.fields.load_b;
			en_irq_a <= ctrl.fields.en_a;
			en_irq_b <= ctrl.fields.en_b;
		end
	end

	// Flag clear pulses, one clock wide.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			clr_a <= 1'b0;
			clr_b <= 1'b0;
		end else begin
			clr_a <= wr_ctrl && ctrl.fields.rst_a;
			clr_b <= wr_ctrl && ctrl.fields.rst_b;
		end
	end

endmodule

`default_nettype wire

// File: rtl/fm_tick_gen.sv
//////////////////////////////
// FM tick generator
// Operator clock enable and per-sample zero tick
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module fm_tick_gen #(
	parameter int DIV = 2 // System clocks per operator slot.
) (
	input  wire  clk,
	input  wire  rst,
	output logic cen,
	output logic zero
);

	localparam int dw        = (DIV > 1) ? $clog2(DIV) : 1; // Divider width.
	localparam int num_slots = 24; // Operator slots per sample.

	logic [dw-1:0] div_cnt; // Clocks left until the next cen.
	logic [4:0]    slot;    // Current operator slot.
	logic          div_end; // Last clock of the divide period.

	assign div_end = (div_cnt == '0);

	// Divider; cen follows div_end by one clock.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			div_cnt <= dw'(DIV - 1);
			cen     <= 1'b0;
			zero    <= 1'b0;
		end else begin
			div_cnt <= div_end ? dw'(DIV - 1) : div_cnt - 1'b1;
			cen     <= div_end;                  // One clock in DIV.
			zero    <= div_end && (slot == '0);  // Rides on cen of slot 0.
		end
	end

	// Slot counter, steps once per cen.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			slot <= '0;
		end else if (div_end) begin
			slot <= (slot == 5'(num_slots - 1)) ? '0 : slot + 1'b1; // Wrap at 24.
		end
	end

endmodule

`default_nettype wire

// File: rtl/fm_timer_pkg.sv
//////////////////////////////
// FM timer shared definitions
// Register map, widths and the control byte
//////////////////////////////
`default_nettype none

package fm_timer_pkg;

	// Host register addresses.
	localparam logic [7:0] addr_ta_hi = 8'h24; // Timer A value, upper 8 bits.
	localparam logic [7:0] addr_ta_lo = 8'h25; // Timer A value, lower 2 bits.
	localparam logic [7:0] addr_tb    = 8'h26; // Timer B value.
	localparam logic [7:0] addr_ctrl  = 8'h27; // Load, enable and clear bits.

	// Counter widths.
	localparam int ta_w = 10; // Timer A, 1024 steps.
	localparam int tb_w = 8;  // Timer B, 256 steps.

	// Layout of the byte written at 0x27, MSB first.
	typedef struct packed {
		logic [1:0] ch3_mode; // Special channel 3 mode, not used by the timers.
		logic       rst_b;    // Clear flag B.
		logic       rst_a;    // Clear flag A.
		logic       en_b;     // IRQ enable B.
		logic       en_a;     // IRQ enable A.
		logic       load_b;   // Run timer B.
		logic       load_a;   // Run timer A.
	} timer_ctrl_s;

	// Same byte seen raw or as fields.
	typedef union packed {
		logic [7:0]  raw;
		timer_ctrl_s fields;
	} timer_ctrl_u;

endpackage

`default_nettype wire
